// File: all.f
slurm16_cpu_pkg.sv
slurm16_bus_pkg.sv
slurm16_instruction_cache.sv
slurm16_load_store.sv
slurm16_memory_arbiter.sv
slurm16_memory_system.sv
slurm16_bus_checker.sv
slurm16_scoreboard.sv
tb_slurm16_memory_system.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the memory system testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_slurm16_memory_system -Mdir obj_dir -o sim_tb -f all.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	exit 1
fi
exit 0

// File: tb_slurm16_memory_system.sv
module tb_slurm16_memory_system;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int MEM_WORDS = 1 << slurm16_bus_pkg::WB_ADR_BITS;
	// Page shared by data traffic and coherence fetches
	localparam logic [8:0] SHARED_PAGE = 9'h1c3;

	logic CLK;
	logic rst;
	slurm16_cpu_pkg::fetch_req_t fetch;
	slurm16_cpu_pkg::fetch_rsp_t fetch_out;
	slurm16_cpu_pkg::ls_req_t data;
	slurm16_cpu_pkg::ls_rsp_t data_out;
	slurm16_bus_pkg::wb_m2s_t bus_out;
	slurm16_bus_pkg::wb_s2m_t bus_in;

	logic [15:0] mem [MEM_WORDS];
	integer mem_seed;
	integer seed;
	logic [31:0] mem_r;
	logic [31:0] r;
	logic [31:0] op;
	logic [31:0] fetch_plan [32];
	logic [31:0] data_plan [32];
	logic [1:0] wait_left;
	logic in_cycle;
	logic [14:0] base;
	logic [14:0] other;
	int tb_errors;
	int sb_errors;
	int reported;
	int tests_run;
	int cycles;
	int cycles_bg;

	slurm16_memory_system UUT (
		.CLK       (CLK),
		.rst       (rst),
		.fetch     (fetch),
		.fetch_out (fetch_out),
		.data      (data),
		.data_out  (data_out),
		.bus_out   (bus_out),
		.bus_in    (bus_in)
	);

	slurm16_scoreboard checks (
		.CLK         (CLK),
		.rst         (rst),
		.fetch       (fetch),
		.fetch_out   (fetch_out),
		.data        (data),
		.data_out    (data_out),
		.error_count (sb_errors)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// ##############################
	// Wishbone memory model
	// ##############################

	initial begin
		mem_seed = 32'h6e2923d0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem_r = $random(mem_seed);
			mem[i[14:0]] = mem_r[15:0];
		end
		bus_in = '0;
		in_cycle = 1'b0;
		wait_left = 2'd0;
		forever begin
			@(negedge CLK);
			if (bus_in.ack) begin
				bus_in.ack = 1'b0;
				in_cycle = 1'b0;
			end else if (bus_out.cyc && bus_out.stb) begin
				// 0 to 3 wait states per transfer
				if (!in_cycle) begin
					mem_r = $random(mem_seed);
					wait_left = mem_r[1:0];
					in_cycle = 1'b1;
				end
				if (wait_left != 2'd0) begin
					wait_left = wait_left - 2'd1;
				end else begin
					bus_in.ack = 1'b1;
					if (bus_out.we) begin
						if (bus_out.sel[1])
							mem[bus_out.adr][15:8] = bus_out.dat[15:8];
						if (bus_out.sel[0])
							mem[bus_out.adr][7:0] = bus_out.dat[7:0];
					end else begin
						bus_in.dat = mem[bus_out.adr];
					end
				end
			end
		end
	end

	// ##############################
	// Request tasks
	// ##############################

	task automatic fetch_word(input logic [14:0] addr, output int took);
		int count;
		logic got;
		fetch.valid = 1'b1;
		fetch.address = addr;
		count = 0;
		got = 1'b0;
		while (!got && count < TIMEOUT_CYCLES) begin
			@(negedge CLK);
			count++;
			got = fetch_out.valid;
		end
		if (!got) begin
			$display("Fetch of address %h got no answer within %0d cycles", addr, TIMEOUT_CYCLES);
			tb_errors++;
		end
		fetch.valid = 1'b0;
		// One quiet cycle lets the cache return to lookup
		@(negedge CLK);
		took = count;
	endtask

	task automatic access_data(input logic write, input logic [14:0] addr,
		input logic [15:0] value, input logic [1:0] mask);
		int count;
		logic got;
		data.valid = 1'b1;
		data.write = write;
		data.address = addr;
		data.store_data = value;
		data.mask = mask;
		count = 0;
		got = 1'b0;
		while (!got && count < TIMEOUT_CYCLES) begin
			@(negedge CLK);
			count++;
			got = data_out.done;
		end
		if (!got) begin
			$display("Data access to address %h never finished", addr);
			tb_errors++;
		end
		data.valid = 1'b0;
		@(negedge CLK);
	endtask

	task automatic check_hit(input logic [14:0] addr, input int took, input logic want_hit);
		if (want_hit && took != 1) begin
			$display("error at %0t: hit on %h answered after %0d cycles", $time, addr, took);
			tb_errors++;
		end else if (!want_hit && took < 2) begin
			$display("error at %0t: fetch of %h answered like a hit", $time, addr);
			tb_errors++;
		end
	endtask

	function automatic int total_errors();
		return tb_errors + sb_errors + UUT.arb0.bus_chk.failures;
	endfunction

	task automatic report_test(input string name);
		$display("test %s: %0d errors", name, total_errors() - reported);
		reported = total_errors();
		tests_run++;
	endtask

	// ##############################
	// Test sequence
	// ##############################

	initial begin
		seed = 32'h6e2923d0;
		rst = 1'b1;
		fetch = '0;
		data = '0;
		tb_errors = 0;
		reported = 0;
		tests_run = 0;
		repeat (4) @(negedge CLK);
		rst = 1'b0;
		@(negedge CLK);

		// Distinct indexes, so every fetch misses
		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			fetch_word({r[9:0], i[4:0]}, cycles);
			check_hit({r[9:0], i[4:0]}, cycles, 1'b0);
		end
		report_test("cold cache fetches");

		r = $random(seed);
		base = r[14:0];
		for (int pass = 0; pass < 2; pass++)
			for (int i = 0; i < 32; i++) begin
				fetch_word(base + i[14:0], cycles);
				if (pass == 1)
					check_hit(base + i[14:0], cycles, 1'b1);
			end
		report_test("cache hits");

		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			base = r[14:0];
			other = base ^ {r[24:15] | 10'd1, 5'd0};
			fetch_word(base, cycles);
			fetch_word(other, cycles);
			check_hit(other, cycles, 1'b0);
			fetch_word(base, cycles);
			check_hit(base, cycles, 1'b0);
		end
		report_test("conflict misses");

		for (int i = 0; i < 40; i++) begin
			r = $random(seed);
			access_data(r[0], {SHARED_PAGE, r[6:1]}, r[31:16], r[8:7]);
		end
		report_test("loads and masked stores");

		for (int i = 0; i < 8; i++) begin
			r = $random(seed);
			base = {SHARED_PAGE, r[5:0]};
			fetch_word(base, cycles);
			access_data(1'b1, base, r[31:16], r[7:6]);
			fetch_word(base, cycles);
			check_hit(base, cycles, 1'b1);
		end
		report_test("store coherence");

		for (int i = 0; i < 32; i++) begin
			fetch_plan[i[4:0]] = $random(seed);
			data_plan[i[4:0]] = $random(seed);
		end
		fork
			begin
				for (int i = 0; i < 32; i++)
					fetch_word({SHARED_PAGE, fetch_plan[i[4:0]][5:0]}, cycles_bg);
			end
			begin
				for (int j = 0; j < 32; j++) begin
					op = data_plan[j[4:0]];
					access_data(op[0], {SHARED_PAGE, op[6:1]}, op[31:16], op[8:7]);
				end
			end
		join
		report_test("concurrent traffic");

		$display("tests %0d, errors %0d", tests_run, total_errors());
		if (total_errors() == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: slurm16_scoreboard.sv
module slurm16_scoreboard (
	input  logic                        CLK,
	input  logic                        rst,
	input  slurm16_cpu_pkg::fetch_req_t fetch,
	input  slurm16_cpu_pkg::fetch_rsp_t fetch_out,
	input  slurm16_cpu_pkg::ls_req_t    data,
	input  slurm16_cpu_pkg::ls_rsp_t    data_out,
	output int                          error_count
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int MEM_WORDS = 1 << slurm16_cpu_pkg::ADDRESS_BITS;

	logic [15:0] shadow [MEM_WORDS];
	integer image_seed;
	logic [31:0] image_word;
	logic fetch_pending;
	logic [14:0] fetch_addr;
	logic data_pending;
	slurm16_cpu_pkg::ls_req_t data_seen;

	// Same seeded image as the bus memory
	initial begin
		image_seed = 32'h6e2923d0;
		error_count = 0;
		for (int i = 0; i < MEM_WORDS; i++) begin
			image_word = $random(image_seed);
			shadow[i[14:0]] = image_word[15:0];
		end
	end

	always @(posedge CLK) begin
		if (rst) begin
			fetch_pending = 1'b0;
			data_pending = 1'b0;
		end else begin
			// Stores land first, a hit in the same cycle already sees them
			if (data_out.done && data_pending) begin
				if (data_seen.write) begin
					// Mask 01 keeps the upper byte, 10 keeps the lower, 00 and 11 write both
					if (data_seen.mask != 2'b01)
						shadow[data_seen.address][15:8] = data_seen.store_data[15:8];
					if (data_seen.mask != 2'b10)
						shadow[data_seen.address][7:0] = data_seen.store_data[7:0];
				end else if (data_out.load_data !== shadow[data_seen.address]) begin
					$display("error at %0t: load from %h returned %h, expected %h", $time,
						data_seen.address, data_out.load_data, shadow[data_seen.address]);
					error_count++;
				end
				data_pending = 1'b0;
			end
			if (fetch_out.valid) begin
				if (!fetch_pending || fetch_out.address !== fetch_addr) begin
					$display("error at %0t: fetch answer for %h, request was %h", $time,
						fetch_out.address, fetch_addr);
					error_count++;
				end else if (fetch_out.instruction !== shadow[fetch_addr]) begin
					$display("error at %0t: fetch from %h returned %h, expected %h", $time,
						fetch_addr, fetch_out.instruction, shadow[fetch_addr]);
					error_count++;
				end
				fetch_pending = 1'b0;
			end
			if (fetch.valid && !fetch_pending) begin
				fetch_pending = 1'b1;
				fetch_addr = fetch.address;
			end
			if (data.valid && !data_pending) begin
				data_pending = 1'b1;
				data_seen = data;
			end
		end
	end

endmodule

// File: slurm16_bus_checker.sv
module slurm16_bus_checker (
	input logic                     CLK,
	input logic                     rst,
	input slurm16_bus_pkg::wb_m2s_t bus_out,
	input slurm16_bus_pkg::wb_s2m_t bus_in
);

	timeunit 1ns;
	timeprecision 1ps;

	int failures = 0;

	// ##############################
	// Wishbone classic rules
	// ##############################

	stb_needs_cyc: assert property (@(posedge CLK) disable iff (rst)
		bus_out.stb |-> bus_out.cyc)
		else begin
			$error("stb is high while cyc is low");
			failures++;
		end

	// Request fields hold until the slave answers
	held_until_ack: assert property (@(posedge CLK) disable iff (rst)
		(bus_out.cyc && !bus_in.ack) |=>
		(bus_out.cyc && $stable(bus_out.adr) && $stable(bus_out.we) && $stable(bus_out.sel)))
		else begin
			$error("adr, we or sel changed before ack");
			failures++;
		end

	cyc_ends_after_ack: assert property (@(posedge CLK) disable iff (rst)
		(bus_out.cyc && bus_in.ack) |=> !bus_out.cyc)
		else begin
			$error("cyc still high the cycle after ack");
			failures++;
		end

	idle_in_reset: assert property (@(posedge CLK) rst |=> !bus_out.cyc)
		else begin
			$error("cyc high during reset");
			failures++;
		end

endmodule

bind slurm16_memory_arbiter slurm16_bus_checker bus_chk (
	.CLK     (CLK),
	.rst     (rst),
	.bus_out (bus_out),
	.bus_in  (bus_in)
);

// File: slurm16_memory_system.sv
module slurm16_memory_system (
	input  logic                        CLK,
	input  logic                        rst,

	// Instruction fetch from the pipeline
	input  slurm16_cpu_pkg::fetch_req_t fetch,
	output slurm16_cpu_pkg::fetch_rsp_t fetch_out,

	// Load and store from the pipeline
	input  slurm16_cpu_pkg::ls_req_t    data,
	output slurm16_cpu_pkg::ls_rsp_t    data_out,

	// Wishbone master port
	output slurm16_bus_pkg::wb_m2s_t    bus_out,
	input  slurm16_bus_pkg::wb_s2m_t    bus_in
);

	slurm16_cpu_pkg::mem_req_t fill_req;
	slurm16_cpu_pkg::mem_rsp_t fill_rsp;
	slurm16_cpu_pkg::mem_req_t data_req;
	slurm16_cpu_pkg::mem_rsp_t data_rsp;

	// Acked stores going back to the cache
	slurm16_cpu_pkg::mem_req_t store_seen;

	slurm16_instruction_cache cache0 (
		.CLK        (CLK),
		.rst        (rst),
		.fetch      (fetch),
		.fetch_out  (fetch_out),
		.fill_req   (fill_req),
		.fill_rsp   (fill_rsp),
		.store_seen (store_seen)
	);

	slurm16_load_store lsu0 (
		.CLK      (CLK),
		.rst      (rst),
		.data     (data),
		.data_out (data_out),
		.mem_out  (data_req),
		.mem_in   (data_rsp)
	);

	slurm16_memory_arbiter arb0 (
		.CLK        (CLK),
		.rst        (rst),
		.data_req   (data_req),
		.data_rsp   (data_rsp),
		.fill_req   (fill_req),
		.fill_rsp   (fill_rsp),
		.store_seen (store_seen),
		.bus_out    (bus_out),
		.bus_in     (bus_in)
	);

endmodule

// File: slurm16_memory_arbiter.sv
module slurm16_memory_arbiter (
	input  logic                      CLK,
	input  logic                      rst,
	input  slurm16_cpu_pkg::mem_req_t data_req,
	output slurm16_cpu_pkg::mem_rsp_t data_rsp,
	input  slurm16_cpu_pkg::mem_req_t fill_req,
	output slurm16_cpu_pkg::mem_rsp_t fill_rsp,
	output slurm16_cpu_pkg::mem_req_t store_seen,
	output slurm16_bus_pkg::wb_m2s_t  bus_out,
	input  slurm16_bus_pkg::wb_s2m_t  bus_in
);

	typedef enum logic [1:0] {st_idle, st_data_grant, st_fill_grant} state_t;

	state_t state;

	slurm16_cpu_pkg::mem_req_t next_req;
	logic data_ack;
	logic fill_ack;

	// Data side wins over cache fills
	assign next_req = data_req.req ? data_req : fill_req;

	assign data_ack = (state == st_data_grant) && bus_in.ack;
	assign fill_ack = (state == st_fill_grant) && bus_in.ack;

	// ##############################
	// Grant FSM and bus cycle
	// ##############################

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= st_idle;
			bus_out.cyc <= 1'b0;
			bus_out.stb <= 1'b0;
			bus_out.we <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (next_req.req) begin
						state <= data_req.req ? st_data_grant : st_fill_grant;
						bus_out.cyc <= 1'b1;
						bus_out.stb <= 1'b1;
						bus_out.we <= next_req.we;
						bus_out.adr <= next_req.address;
						bus_out.dat <= next_req.data;
						bus_out.sel <= next_req.mask;
					end
				end
				st_data_grant, st_fill_grant: begin
					// Cycle ends the clock after ack and idle lasts at least one cycle
					if (bus_in.ack) begin
						state <= st_idle;
						bus_out.cyc <= 1'b0;
						bus_out.stb <= 1'b0;
						bus_out.we <= 1'b0;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// ##############################
	// Response steering
	// ##############################

	always_comb begin
		data_rsp.ack = data_ack;
		data_rsp.data = data_ack ? bus_in.dat : '0;
		fill_rsp.ack = fill_ack;
		fill_rsp.data = fill_ack ? bus_in.dat : '0;
	end

	// Store notice for the cache in the ack cycle
	// Lands in the lines before the load/store unit reports done
	always_comb begin
		store_seen.req = data_ack && bus_out.we;
		store_seen.we = bus_out.we;
		store_seen.address = bus_out.adr;
		store_seen.data = bus_out.dat;
		store_seen.mask = bus_out.sel;
	end

endmodule

// File: slurm16_load_store.sv
module slurm16_load_store (
	input  logic                      CLK,
	input  logic                      rst,
	input  slurm16_cpu_pkg::ls_req_t  data,
	output slurm16_cpu_pkg::ls_rsp_t  data_out,
	output slurm16_cpu_pkg::mem_req_t mem_out,
	input  slurm16_cpu_pkg::mem_rsp_t mem_in
);

	logic idle;
	logic [1:0] byte_sel;

	// Unit is free whenever no memory request is pending
	assign idle = !mem_out.req;

	// Loads read the whole word
	// Zero mask on a store means both bytes
	always_comb begin
		if (!data.write || data.mask == 2'b00)
			byte_sel = 2'b11;
		else
			byte_sel = data.mask;
	end

	// ##############################
	// Request holder
	// ##############################

	always_ff @(posedge CLK) begin
		if (rst) begin
			mem_out.req <= 1'b0;
		end else if (idle) begin
			if (data.valid) begin
				mem_out.req <= 1'b1;
				mem_out.we <= data.write;
				mem_out.address <= data.address;
				mem_out.data <= data.store_data;
				mem_out.mask <= byte_sel;
			end
		end else if (mem_in.ack) begin
			// Held until the arbiter acknowledges
			mem_out.req <= 1'b0;
		end
	end

	// ##############################
	// Completion
	// ##############################

	always_ff @(posedge CLK) begin
		if (rst) begin
			data_out.done <= 1'b0;
		end else begin
			data_out.done <= 1'b0;
			if (!idle && mem_in.ack) begin
				data_out.done <= 1'b1;
				// Stores leave the last load word in place
				if (!mem_out.we)
					data_out.load_data <= mem_in.data;
			end
		end
	end

endmodule

// File: slurm16_instruction_cache.sv
module slurm16_instruction_cache (
	input  logic                         CLK,
	input  logic                         rst,
	input  slurm16_cpu_pkg::fetch_req_t  fetch,
	output slurm16_cpu_pkg::fetch_rsp_t  fetch_out,
	output slurm16_cpu_pkg::mem_req_t    fill_req,
	input  slurm16_cpu_pkg::mem_rsp_t    fill_rsp,
	input  slurm16_cpu_pkg::mem_req_t    store_seen
);

	typedef enum logic [1:0] {st_lookup, st_fill_wait, st_respond} state_t;

	state_t state;

	// One word per line
	logic [slurm16_cpu_pkg::BITS - 1:0] line_data [1 << slurm16_cpu_pkg::CACHE_INDEX_BITS];
	logic [slurm16_cpu_pkg::CACHE_TAG_BITS - 1:0] line_tag [1 << slurm16_cpu_pkg::CACHE_INDEX_BITS];
	logic [(1 << slurm16_cpu_pkg::CACHE_INDEX_BITS) - 1:0] line_valid;

	logic [slurm16_cpu_pkg::CACHE_INDEX_BITS - 1:0] fetch_index;
	logic [slurm16_cpu_pkg::CACHE_INDEX_BITS - 1:0] fill_index;
	logic [slurm16_cpu_pkg::CACHE_INDEX_BITS - 1:0] snoop_index;
	logic [slurm16_cpu_pkg::CACHE_TAG_BITS - 1:0] fetch_tag;
	logic [slurm16_cpu_pkg::CACHE_TAG_BITS - 1:0] fill_tag;
	logic [slurm16_cpu_pkg::CACHE_TAG_BITS - 1:0] snoop_tag;
	logic hit;
	logic snoop_hit;
	logic [slurm16_cpu_pkg::BITS - 1:0] snoop_word;
	logic [slurm16_cpu_pkg::BITS - 1:0] hit_word;

	function automatic logic [slurm16_cpu_pkg::BITS - 1:0] merge_bytes(
		input logic [slurm16_cpu_pkg::BITS - 1:0] old_word,
		input logic [slurm16_cpu_pkg::BITS - 1:0] new_word,
		input logic [1:0] mask
	);
		logic [slurm16_cpu_pkg::BITS - 1:0] result;
		result = old_word;
		if (mask[1])
			result[15:8] = new_word[15:8];
		if (mask[0])
			result[7:0] = new_word[7:0];
		return result;
	endfunction

	// ##############################
	// Address split and tag compare
	// ##############################

	assign fetch_index = fetch.address[slurm16_cpu_pkg::CACHE_INDEX_BITS - 1:0];
	assign fetch_tag = fetch.address[slurm16_cpu_pkg::ADDRESS_BITS - 1:slurm16_cpu_pkg::CACHE_INDEX_BITS];
	assign fill_index = fill_req.address[slurm16_cpu_pkg::CACHE_INDEX_BITS - 1:0];
	assign fill_tag = fill_req.address[slurm16_cpu_pkg::ADDRESS_BITS - 1:slurm16_cpu_pkg::CACHE_INDEX_BITS];
	assign snoop_index = store_seen.address[slurm16_cpu_pkg::CACHE_INDEX_BITS - 1:0];
	assign snoop_tag = store_seen.address[slurm16_cpu_pkg::ADDRESS_BITS - 1:slurm16_cpu_pkg::CACHE_INDEX_BITS];

	assign hit = line_valid[fetch_index] && (line_tag[fetch_index] == fetch_tag);
	assign snoop_hit = store_seen.req && store_seen.we && line_valid[snoop_index] &&
		(line_tag[snoop_index] == snoop_tag);
	assign snoop_word = merge_bytes(line_data[snoop_index], store_seen.data, store_seen.mask);

	// A store landing on the looked-up word in the same cycle is forwarded
	assign hit_word = (snoop_hit && store_seen.address == fetch.address) ? snoop_word :
		line_data[fetch_index];

	// ##############################
	// Line storage
	// ##############################

	always_ff @(posedge CLK) begin
		if (snoop_hit)
			line_data[snoop_index] <= snoop_word;
		// Fill and store notice never share a cycle, one bus transfer at a time
		if (state == st_fill_wait && fill_rsp.ack) begin
			line_data[fill_index] <= fill_rsp.data;
			line_tag[fill_index] <= fill_tag;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst)
			line_valid <= '0;
		else if (state == st_fill_wait && fill_rsp.ack)
			line_valid[fill_index] <= 1'b1;
	end

	// ##############################
	// Lookup FSM
	// ##############################

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= st_lookup;
			fetch_out.valid <= 1'b0;
			fill_req.req <= 1'b0;
		end else begin
			case (state)
				st_lookup: begin
					if (fetch.valid) begin
						if (hit) begin
							fetch_out.valid <= 1'b1;
							fetch_out.instruction <= hit_word;
							fetch_out.address <= fetch.address;
							state <= st_respond;
						end else begin
							// Single word read for the missing line
							fill_req.req <= 1'b1;
							fill_req.we <= 1'b0;
							fill_req.address <= fetch.address;
							fill_req.data <= '0;
							fill_req.mask <= 2'b11;
							state <= st_fill_wait;
						end
					end
				end
				st_fill_wait: begin
					if (fill_rsp.ack) begin
						fill_req.req <= 1'b0;
						fetch_out.valid <= 1'b1;
						fetch_out.instruction <= fill_rsp.data;
						fetch_out.address <= fill_req.address;
						state <= st_respond;
					end
				end
				st_respond: begin
					// Response is a single cycle pulse
					fetch_out.valid <= 1'b0;
					state <= st_lookup;
				end
				default: state <= st_lookup;
			endcase
		end
	end

endmodule

// File: slurm16_bus_pkg.sv
package slurm16_bus_pkg;

	// Wishbone classic port sizes
	localparam int WB_ADR_BITS = 15;
	localparam int WB_DAT_BITS = 16;
	localparam int WB_SEL_BITS = 2;

	// ##############################
	// Master outputs
	// ##############################

	// sel[1] selects dat[15:8] and sel[0] selects dat[7:0]
	typedef struct packed {
		logic                     cyc;
		logic                     stb;
		logic                     we;
		logic [WB_ADR_BITS - 1:0] adr;
		logic [WB_DAT_BITS - 1:0] dat;
		logic [WB_SEL_BITS - 1:0] sel;
	} wb_m2s_t;

	// ##############################
	// Slave outputs
	// ##############################

	// One ack per strobe, classic cycles only
	typedef struct packed {
		logic                     ack;
		logic [WB_DAT_BITS - 1:0] dat;
	} wb_s2m_t;

endpackage

// File: slurm16_cpu_pkg.sv
package slurm16_cpu_pkg;

	// Word and address sizes seen by the pipeline
	localparam int BITS = 16;
	localparam int ADDRESS_BITS = 15;

	// Direct-mapped instruction cache geometry
	localparam int CACHE_INDEX_BITS = 5;
	localparam int CACHE_TAG_BITS = 10;

	// ##############################
	// Pipeline side
	// ##############################

	typedef struct packed {
		logic                      valid;
		logic [ADDRESS_BITS - 1:0] address;
	} fetch_req_t;

	// Address travels back with the instruction word
	typedef struct packed {
		logic                      valid;
		logic [BITS - 1:0]         instruction;
		logic [ADDRESS_BITS - 1:0] address;
	} fetch_rsp_t;

	typedef struct packed {
		logic                      valid;
		logic                      write;
		logic [ADDRESS_BITS - 1:0] address;
		logic [BITS - 1:0]         store_data;
		logic [1:0]                mask;
	} ls_req_t;

	typedef struct packed {
		logic              done;
		logic [BITS - 1:0] load_data;
	} ls_rsp_t;

	// ##############################
	// Arbiter side
	// ##############################

	typedef struct packed {
		logic                      req;
		logic                      we;
		logic [ADDRESS_BITS - 1:0] address;
		logic [BITS - 1:0]         data;
		logic [1:0]                mask;
	} mem_req_t;

	typedef struct packed {
		logic              ack;
		logic [BITS - 1:0] data;
	} mem_rsp_t;

endpackage
